// ==== hdl/cpu_params.svh ====
// Data width, register file size, instruction field positions and reset PC

`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Data and address width
`define XLEN 32

// Register file
`define REG_COUNT 32
`define REG_ADDR_W 5

// Instruction fields
`define OPCODE_MSB 31
`define OPCODE_LSB 26
`define RD_MSB 25
`define RS_MSB 20
`define RT_MSB 15
`define IMM_W 16

// First fetch address
`define RESET_PC 32'h0000_0000

`endif

// ==== hdl/cpuPkg.sv ====
// Opcode, control state and forwarding enums plus the stage bus structs

`include "cpu_params.svh"

package cpuPkg;

	typedef enum logic [`OPCODE_MSB-`OPCODE_LSB:0] {
		opNop   = 6'h00,
		opAdd   = 6'h01,
		opSub   = 6'h02,
		opAnd   = 6'h03,
		opOr    = 6'h04,
		opXor   = 6'h05,
		opAddi  = 6'h08,
		opLoad  = 6'h10,
		opStore = 6'h11,
		opHalt  = 6'h3f
	} opcode_t;

	typedef enum logic [1:0] {
		stRun,
		stMemWait,
		stDrain,
		stHalted
	} ctrlState_t;

	typedef enum logic [1:0] {
		fwdNone,
		fwdMem,
		fwdWb
	} fwdSel_t;

	// rt holds the second source register, which is rd for a store
	typedef struct packed {
		logic valid;
		opcode_t op;
		logic [`REG_ADDR_W-1:0] rd;
		logic [`REG_ADDR_W-1:0] rs;
		logic [`REG_ADDR_W-1:0] rt;
		logic [`XLEN-1:0] opA;
		logic [`XLEN-1:0] opB;
		logic [`XLEN-1:0] imm;
	} idExBus_t;

	typedef struct packed {
		logic valid;
		opcode_t op;
		logic [`REG_ADDR_W-1:0] rd;
		logic [`XLEN-1:0] result;
		logic [`XLEN-1:0] storeData;
		logic we;
	} exMemBus_t;

	typedef struct packed {
		logic we;
		logic [`REG_ADDR_W-1:0] addr;
		logic [`XLEN-1:0] data;
		logic halt;
	} wbBus_t;

	typedef struct packed {
		logic valid;
		logic write;
		logic [`XLEN-1:0] addr;
		logic [`XLEN-1:0] wrData;
	} dataReq_t;

endpackage

// ==== hdl/pipelineControl.sv ====
// Pipeline control FSM with stall, drain and halt generation

`timescale 1ns/1ns

module pipelineControl (
	input  logic clk,
	input  logic rst_n,
	input  logic memBusy,
	input  logic loadUseHazard,
	input  logic haltDecoded,
	input  logic haltRetired,
	output logic stallAll,
	output logic stallFront,
	output logic drain,
	output logic halt
);

	cpuPkg::ctrlState_t state;
	cpuPkg::ctrlState_t stateNext;
	logic haltAccepted;

	assign stallAll = memBusy;
	assign stallFront = loadUseHazard && !memBusy;

	// Halt moves into ID/EX only when nothing holds the front end
	assign haltAccepted = haltDecoded && !stallAll && !stallFront;

	assign drain = (state == cpuPkg::stDrain) || (state == cpuPkg::stHalted);
	assign halt = haltRetired || (state == cpuPkg::stHalted);

	always_comb begin
		stateNext = state;
		case (state)
			cpuPkg::stRun, cpuPkg::stMemWait: begin
				if (haltAccepted)
					stateNext = cpuPkg::stDrain;
				else if (memBusy)
					stateNext = cpuPkg::stMemWait;
				else
					stateNext = cpuPkg::stRun;
			end
			// Older loads and stores may still wait on the data port here
			cpuPkg::stDrain: begin
				if (haltRetired)
					stateNext = cpuPkg::stHalted;
			end
			default: stateNext = cpuPkg::stHalted;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			state <= cpuPkg::stRun;
		else
			state <= stateNext;
	end

	// Sticky until reset
	haltHeld: assert property (@(posedge clk) disable iff (!rst_n) halt |=> halt);

endmodule

// ==== hdl/fetchUnit.sv ====
// Program counter, instruction port requests and the fetched instruction buffer

`timescale 1ns/1ns

`include "cpu_params.svh"

module fetchUnit (
	input  logic clk,
	input  logic rst_n,
	input  logic stallFront,
	input  logic stallAll,
	input  logic drain,
	output logic [`XLEN-1:0] instrAddr,
	output logic instrValid,
	input  logic [`XLEN-1:0] instrData,
	input  logic instrReady,
	output logic [`XLEN-1:0] fetched,
	output logic fetchedValid
);

	logic [`XLEN-1:0] pc;
	logic bufValid;
	logic started;
	logic pending;
	logic consume;
	logic room;
	logic accept;

	// Decode takes the buffered word whenever it is not stalled
	assign consume = bufValid && !stallAll && !stallFront;
	assign room = !bufValid || consume;

	// An open request stays up until accepted, even once draining starts
	assign instrValid = pending || (started && !drain && room);
	assign instrAddr = pc;
	assign accept = instrValid && instrReady;
	assign fetchedValid = bufValid;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= `RESET_PC;
			bufValid <= 1'b0;
			started <= 1'b0;
			pending <= 1'b0;
		end else begin
			started <= 1'b1;
			pending <= instrValid && !instrReady;
			if (accept) begin
				pc <= pc + `XLEN'(4);
				bufValid <= 1'b1;
			end else if (consume) begin
				bufValid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			fetched <= instrData;
	end

	addrHeld: assert property (@(posedge clk) disable iff (!rst_n)
		instrValid && !instrReady |=> instrValid && $stable(instrAddr));

endmodule

// ==== hdl/registerFile.sv ====
// Three read port register file with write-through bypass and a zero register

`timescale 1ns/1ns

`include "cpu_params.svh"

module registerFile (
	input  logic clk,
	input  logic rst_n,
	input  logic [`REG_ADDR_W-1:0] rsAddr,
	input  logic [`REG_ADDR_W-1:0] rtAddr,
	input  logic [`REG_ADDR_W-1:0] rdAddr,
	output logic [`XLEN-1:0] rsData,
	output logic [`XLEN-1:0] rtData,
	output logic [`XLEN-1:0] rdData,
	input  cpuPkg::wbBus_t wb
);

	logic [`XLEN-1:0] regs [`REG_COUNT];

	function automatic logic [`XLEN-1:0] readPort(
		input logic [`REG_ADDR_W-1:0] addr,
		input logic [`XLEN-1:0] stored,
		input cpuPkg::wbBus_t wbIn
	);
		if (addr == '0)
			return '0;
		// Same cycle write shows up at once
		if (wbIn.we && wbIn.addr == addr)
			return wbIn.data;
		return stored;
	endfunction

	assign rsData = readPort(rsAddr, regs[rsAddr], wb);
	assign rtData = readPort(rtAddr, regs[rtAddr], wb);
	assign rdData = readPort(rdAddr, regs[rdAddr], wb);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end else if (wb.we && wb.addr != '0) begin
			regs[wb.addr] <= wb.data;
		end
	end

endmodule

// ==== hdl/decodeStage.sv ====
// Instruction field split, opcode decode and the ID/EX register

`timescale 1ns/1ns

`include "cpu_params.svh"

module decodeStage (
	input  logic clk,
	input  logic rst_n,
	input  logic [`XLEN-1:0] fetched,
	input  logic fetchedValid,
	input  logic stallAll,
	input  logic stallFront,
	input  logic drain,
	output logic [`REG_ADDR_W-1:0] rsAddr,
	output logic [`REG_ADDR_W-1:0] rtAddr,
	output logic [`REG_ADDR_W-1:0] rdAddr,
	input  logic [`XLEN-1:0] rsData,
	input  logic [`XLEN-1:0] rtData,
	input  logic [`XLEN-1:0] rdData,
	output logic [`REG_ADDR_W-1:0] nextRs,
	output logic [`REG_ADDR_W-1:0] nextRt,
	output cpuPkg::idExBus_t idEx,
	output logic haltDecoded
);

	cpuPkg::opcode_t op;
	cpuPkg::idExBus_t idExNext;
	logic [`XLEN-1:0] immExt;
	logic decValid;
	logic usesRs;
	logic usesRt;
	logic isStore;

	assign rsAddr = fetched[`RS_MSB -: `REG_ADDR_W];
	assign rtAddr = fetched[`RT_MSB -: `REG_ADDR_W];
	assign rdAddr = fetched[`RD_MSB -: `REG_ADDR_W];
	assign immExt = {{(`XLEN-`IMM_W){fetched[`IMM_W-1]}}, fetched[`IMM_W-1:0]};

	// Everything behind a decoded halt becomes a bubble
	assign decValid = fetchedValid && !drain;

	always_comb begin
		case (fetched[`OPCODE_MSB:`OPCODE_LSB])
			cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd, cpuPkg::opOr, cpuPkg::opXor,
			cpuPkg::opAddi, cpuPkg::opLoad, cpuPkg::opStore, cpuPkg::opHalt:
				op = cpuPkg::opcode_t'(fetched[`OPCODE_MSB:`OPCODE_LSB]);
			default: op = cpuPkg::opNop;
		endcase
	end

	assign isStore = (op == cpuPkg::opStore);
	assign usesRt = (op == cpuPkg::opAdd) || (op == cpuPkg::opSub) || (op == cpuPkg::opAnd)
		|| (op == cpuPkg::opOr) || (op == cpuPkg::opXor);
	assign usesRs = usesRt || isStore || (op == cpuPkg::opAddi) || (op == cpuPkg::opLoad);

	// Unused sources read as r0 so they never forward or stall
	assign nextRs = (decValid && usesRs) ? rsAddr : '0;
	assign nextRt = !decValid ? '0 : (isStore ? rdAddr : (usesRt ? rtAddr : '0));
	assign haltDecoded = decValid && (op == cpuPkg::opHalt);

	always_comb begin
		idExNext.valid = decValid && !stallFront;
		idExNext.op = op;
		idExNext.rd = rdAddr;
		idExNext.rs = nextRs;
		idExNext.rt = nextRt;
		idExNext.opA = rsData;
		idExNext.opB = isStore ? rdData : rtData;
		idExNext.imm = immExt;
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			idEx.valid <= 1'b0;
		else if (!stallAll)
			idEx <= idExNext;
	end

endmodule

// ==== hdl/executeStage.sv ====
// Operand forwarding, ALU, load-use detection and the EX/MEM register

`timescale 1ns/1ns

`include "cpu_params.svh"

module executeStage (
	input  logic clk,
	input  logic rst_n,
	input  logic stallAll,
	input  cpuPkg::idExBus_t idEx,
	input  logic [`REG_ADDR_W-1:0] nextRs,
	input  logic [`REG_ADDR_W-1:0] nextRt,
	input  cpuPkg::exMemBus_t memFwd,
	input  cpuPkg::wbBus_t wb,
	output cpuPkg::exMemBus_t exMem,
	output logic loadUseHazard
);

	cpuPkg::fwdSel_t selA;
	cpuPkg::fwdSel_t selB;
	cpuPkg::exMemBus_t exMemNext;
	logic [`XLEN-1:0] valA;
	logic [`XLEN-1:0] valB;
	logic [`XLEN-1:0] aluOut;
	logic writesReg;

	function automatic cpuPkg::fwdSel_t pickSource(
		input logic [`REG_ADDR_W-1:0] src,
		input cpuPkg::exMemBus_t memSide,
		input cpuPkg::wbBus_t wbSide
	);
		if (src == '0)
			return cpuPkg::fwdNone;
		// A load in MEM has only its address, the load-use stall covers it
		if (memSide.valid && memSide.we && memSide.op != cpuPkg::opLoad && memSide.rd == src)
			return cpuPkg::fwdMem;
		if (wbSide.we && wbSide.addr == src)
			return cpuPkg::fwdWb;
		return cpuPkg::fwdNone;
	endfunction

	function automatic logic [`XLEN-1:0] forwardValue(
		input cpuPkg::fwdSel_t sel,
		input logic [`XLEN-1:0] regValue,
		input logic [`XLEN-1:0] memValue,
		input logic [`XLEN-1:0] wbValue
	);
		case (sel)
			cpuPkg::fwdMem: return memValue;
			cpuPkg::fwdWb: return wbValue;
			default: return regValue;
		endcase
	endfunction

	assign selA = pickSource(idEx.rs, memFwd, wb);
	assign selB = pickSource(idEx.rt, memFwd, wb);
	assign valA = forwardValue(selA, idEx.opA, memFwd.result, wb.data);
	assign valB = forwardValue(selB, idEx.opB, memFwd.result, wb.data);

	always_comb begin
		writesReg = 1'b1;
		case (idEx.op)
			cpuPkg::opAdd: aluOut = valA + valB;
			cpuPkg::opSub: aluOut = valA - valB;
			cpuPkg::opAnd: aluOut = valA & valB;
			cpuPkg::opOr: aluOut = valA | valB;
			cpuPkg::opXor: aluOut = valA ^ valB;
			cpuPkg::opAddi, cpuPkg::opLoad: aluOut = valA + idEx.imm;
			cpuPkg::opStore: begin
				aluOut = valA + idEx.imm;
				writesReg = 1'b0;
			end
			default: begin
				aluOut = '0;
				writesReg = 1'b0;
			end
		endcase
	end

	always_comb begin
		exMemNext.valid = idEx.valid;
		exMemNext.op = idEx.op;
		exMemNext.rd = idEx.rd;
		exMemNext.result = aluOut;
		exMemNext.storeData = valB;
		exMemNext.we = idEx.valid && writesReg;
	end

	// Load in EX feeding the instruction now in decode
	assign loadUseHazard = idEx.valid && (idEx.op == cpuPkg::opLoad) && (idEx.rd != '0)
		&& ((idEx.rd == nextRs) || (idEx.rd == nextRt));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			exMem.valid <= 1'b0;
			exMem.we <= 1'b0;
		end else if (!stallAll) begin
			exMem <= exMemNext;
		end
	end

endmodule

// ==== hdl/memoryStage.sv ====
// Data port requests, load data capture and the MEM/WB register

`timescale 1ns/1ns

`include "cpu_params.svh"

module memoryStage (
	input  logic clk,
	input  logic rst_n,
	input  cpuPkg::exMemBus_t exMem,
	output cpuPkg::dataReq_t dataReq,
	input  logic [`XLEN-1:0] dataRdData,
	input  logic dataReady,
	output logic memBusy,
	output cpuPkg::wbBus_t wb,
	output logic haltRetired
);

	logic isLoad;
	logic isStore;
	logic [`XLEN-1:0] wbValue;

	assign isLoad = exMem.valid && (exMem.op == cpuPkg::opLoad);
	assign isStore = exMem.valid && (exMem.op == cpuPkg::opStore);

	always_comb begin
		dataReq.valid = isLoad || isStore;
		dataReq.write = isStore;
		dataReq.addr = exMem.result;
		dataReq.wrData = exMem.storeData;
	end

	// Whole pipeline waits on the data port
	assign memBusy = dataReq.valid && !dataReady;
	assign wbValue = isLoad ? dataRdData : exMem.result;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb.we <= 1'b0;
			wb.halt <= 1'b0;
		end else if (!memBusy) begin
			wb.we <= exMem.valid && exMem.we;
			wb.addr <= exMem.rd;
			wb.data <= wbValue;
			wb.halt <= exMem.valid && (exMem.op == cpuPkg::opHalt);
		end
	end

	assign haltRetired = wb.halt;

	// Frozen EX/MEM keeps an unanswered request unchanged
	reqHeld: assert property (@(posedge clk) disable iff (!rst_n)
		dataReq.valid && !dataReady |=> dataReq.valid && $stable(dataReq));

endmodule

// ==== hdl/cpuTop.sv ====
// Five-stage core top level connecting control, fetch, decode, execute and memory

`timescale 1ns/1ns

`include "cpu_params.svh"

module cpuTop (
	input  logic clk,
	input  logic rst_n,
	output logic [`XLEN-1:0] instrAddr,
	output logic instrValid,
	input  logic [`XLEN-1:0] instrData,
	input  logic instrReady,
	output cpuPkg::dataReq_t dataReq,
	input  logic [`XLEN-1:0] dataRdData,
	input  logic dataReady,
	output logic halt
);

	logic stallAll;
	logic stallFront;
	logic drain;
	logic memBusy;
	logic loadUseHazard;
	logic haltDecoded;
	logic haltRetired;
	logic [`XLEN-1:0] fetched;
	logic fetchedValid;
	logic [`REG_ADDR_W-1:0] rsAddr;
	logic [`REG_ADDR_W-1:0] rtAddr;
	logic [`REG_ADDR_W-1:0] rdAddr;
	logic [`REG_ADDR_W-1:0] nextRs;
	logic [`REG_ADDR_W-1:0] nextRt;
	logic [`XLEN-1:0] rsData;
	logic [`XLEN-1:0] rtData;
	logic [`XLEN-1:0] rdData;
	cpuPkg::idExBus_t idEx;
	cpuPkg::exMemBus_t exMem;
	cpuPkg::wbBus_t wb;

	pipelineControl control (
		.clk(clk),
		.rst_n(rst_n),
		.memBusy(memBusy),
		.loadUseHazard(loadUseHazard),
		.haltDecoded(haltDecoded),
		.haltRetired(haltRetired),
		.stallAll(stallAll),
		.stallFront(stallFront),
		.drain(drain),
		.halt(halt)
	);

	fetchUnit fetch (
		.clk(clk),
		.rst_n(rst_n),
		.stallFront(stallFront),
		.stallAll(stallAll),
		.drain(drain),
		.instrAddr(instrAddr),
		.instrValid(instrValid),
		.instrData(instrData),
		.instrReady(instrReady),
		.fetched(fetched),
		.fetchedValid(fetchedValid)
	);

	registerFile regs (
		.clk(clk),
		.rst_n(rst_n),
		.rsAddr(rsAddr),
		.rtAddr(rtAddr),
		.rdAddr(rdAddr),
		.rsData(rsData),
		.rtData(rtData),
		.rdData(rdData),
		.wb(wb)
	);

	decodeStage decode (
		.clk(clk),
		.rst_n(rst_n),
		.fetched(fetched),
		.fetchedValid(fetchedValid),
		.stallAll(stallAll),
		.stallFront(stallFront),
		.drain(drain),
		.rsAddr(rsAddr),
		.rtAddr(rtAddr),
		.rdAddr(rdAddr),
		.rsData(rsData),
		.rtData(rtData),
		.rdData(rdData),
		.nextRs(nextRs),
		.nextRt(nextRt),
		.idEx(idEx),
		.haltDecoded(haltDecoded)
	);

	// MEM forwarding taps the EX/MEM register straight back
	executeStage execute (
		.clk(clk),
		.rst_n(rst_n),
		.stallAll(stallAll),
		.idEx(idEx),
		.nextRs(nextRs),
		.nextRt(nextRt),
		.memFwd(exMem),
		.wb(wb),
		.exMem(exMem),
		.loadUseHazard(loadUseHazard)
	);

	memoryStage memory (
		.clk(clk),
		.rst_n(rst_n),
		.exMem(exMem),
		.dataReq(dataReq),
		.dataRdData(dataRdData),
		.dataReady(dataReady),
		.memBusy(memBusy),
		.wb(wb),
		.haltRetired(haltRetired)
	);

endmodule

// ==== sim/tbMemories.sv ====
// Word memory model for the instruction and data ports, with ready latency and a store log

`timescale 1ns/1ns

module portMemory (
	input  logic clk,
	input  logic rst_n,
	input  logic waitEnable,
	input  logic valid,
	input  logic write,
	input  logic [31:0] addr,
	input  logic [31:0] wrData,
	output logic [31:0] rdData,
	output logic ready
);

	// 256 words, indexed by address bits 9:2
	logic [31:0] mem [256];

	// Wait cycles per transfer, filled from the seeded generator in the testbench
	logic [1:0] waitTable [1024];

	// Address in the upper half, data in the lower half
	logic [63:0] storeLog [$];

	int unsigned transfers;
	int unsigned waitLeft;

	initial begin
		rdData = 32'h0;
		ready = 1'b0;
		transfers = 0;
		waitLeft = 0;
	end

	// Transfer happens where valid and ready are both high
	always @(posedge clk) begin
		if (!rst_n) begin
			waitLeft <= 0;
		end else if (valid && ready) begin
			waitLeft <= waitEnable ? waitTable[transfers % 1024] : 0;
			transfers <= transfers + 1;
			if (write) begin
				mem[addr[9:2]] <= wrData;
				storeLog.push_back({addr, wrData});
			end
		end else if (valid && waitLeft != 0) begin
			waitLeft <= waitLeft - 1;
		end
	end

	// Responses change on the falling edge only
	always @(negedge clk) begin
		ready <= (waitLeft == 0);
		rdData <= mem[addr[9:2]];
	end

endmodule

// ==== sim/cpuTb.sv ====
// Testbench top with clock, reset, test programs, reference model, store checks and watchdog

`timescale 1ns/1ns

`include "cpu_params.svh"

module cpuTb;

	localparam int MEM_WORDS = 256;
	localparam int RANDOM_LEN = 64;
	localparam int SETTLE_CYCLES = 4;
	localparam int HOLD_CYCLES = 16;

	logic clk;
	logic rst_n;
	logic [`XLEN-1:0] instrAddr;
	logic instrValid;
	logic [`XLEN-1:0] instrData;
	logic instrReady;
	cpuPkg::dataReq_t dataReq;
	logic [`XLEN-1:0] dataRdData;
	logic dataReady;
	logic halt;
	logic waitEnable;

	logic [31:0] progWords [$];
	int progStart [4];
	int progLen [4];
	int totalInstr;
	logic [31:0] refMem [MEM_WORDS];
	logic [31:0] expAddr [$];
	logic [31:0] expData [$];
	logic [31:0] fetchAddr;
	int storeIdx;
	bit checking;
	int errorCount;
	int testsRun;
	int testsFailed;

	cpuTop i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.instrAddr(instrAddr),
		.instrValid(instrValid),
		.instrData(instrData),
		.instrReady(instrReady),
		.dataReq(dataReq),
		.dataRdData(dataRdData),
		.dataReady(dataReady),
		.halt(halt)
	);

	portMemory instrMem (
		.clk(clk),
		.rst_n(rst_n),
		.waitEnable(waitEnable),
		.valid(instrValid),
		.write(1'b0),
		.addr(instrAddr),
		.wrData(32'h0),
		.rdData(instrData),
		.ready(instrReady)
	);

	portMemory dataMem (
		.clk(clk),
		.rst_n(rst_n),
		.waitEnable(waitEnable),
		.valid(dataReq.valid),
		.write(dataReq.write),
		.addr(dataReq.addr),
		.wrData(dataReq.wrData),
		.rdData(dataRdData),
		.ready(dataReady)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] encReg(input cpuPkg::opcode_t op, input int rd,
		input int rs, input int rt);
		return {op, rd[4:0], rs[4:0], rt[4:0], 11'h0};
	endfunction

	function automatic logic [31:0] encImm(input cpuPkg::opcode_t op, input int rd,
		input int rs, input int imm);
		return {op, rd[4:0], rs[4:0], imm[15:0]};
	endfunction

	function automatic cpuPkg::opcode_t aluOp(input int n);
		case (n)
			0: return cpuPkg::opAdd;
			1: return cpuPkg::opSub;
			2: return cpuPkg::opAnd;
			3: return cpuPkg::opOr;
			default: return cpuPkg::opXor;
		endcase
	endfunction

	// Initial data word, every index bit shows up
	function automatic logic [31:0] fillWord(input int idx);
		return {idx[7:0], ~idx[7:0], idx[7:0] ^ 8'h5a, 8'hc3};
	endfunction

	// Nop words past the end of a program
	function automatic logic [31:0] nopFill(input int idx);
		return {6'h00, 18'h0, idx[7:0]};
	endfunction

	// Runs the program in order up to its halt; fills refMem and the expected stores
	function automatic int runReference(input int first, input int count);
		logic [31:0] regs [32];
		logic [31:0] word;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] addr;
		logic [5:0] opc;
		int rd;
		int retired;
		for (int i = 0; i < 32; i++)
			regs[i] = 32'h0;
		for (int i = 0; i < MEM_WORDS; i++)
			refMem[i] = fillWord(i);
		expAddr.delete();
		expData.delete();
		retired = 0;
		for (int pc = 0; pc < count; pc++) begin
			word = progWords[first + pc];
			opc = word[31:26];
			rd = word[25:21];
			a = regs[word[20:16]];
			b = regs[word[15:11]];
			imm = {{16{word[15]}}, word[15:0]};
			addr = a + imm;
			retired++;
			if (opc == cpuPkg::opHalt)
				break;
			case (opc)
				cpuPkg::opAdd: regs[rd] = a + b;
				cpuPkg::opSub: regs[rd] = a - b;
				cpuPkg::opAnd: regs[rd] = a & b;
				cpuPkg::opOr: regs[rd] = a | b;
				cpuPkg::opXor: regs[rd] = a ^ b;
				cpuPkg::opAddi: regs[rd] = addr;
				cpuPkg::opLoad: regs[rd] = refMem[addr[9:2]];
				cpuPkg::opStore: begin
					refMem[addr[9:2]] = regs[rd];
					expAddr.push_back(addr);
					expData.push_back(regs[rd]);
				end
				default: ;
			endcase
			regs[0] = 32'h0;
		end
		return retired;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("FAIL at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
			errorCount++;
		end
	endtask

	task automatic addInstr(input logic [31:0] word);
		progWords.push_back(word);
	endtask

	task automatic buildPrograms();
		int kind;
		int rd;
		int rs;
		int rt;
		// Dependent ALU chain with each result stored
		progStart[0] = progWords.size();
		addInstr(encImm(cpuPkg::opAddi, 1, 0, 16'h0123));
		addInstr(encImm(cpuPkg::opStore, 1, 0, 16'h0100));
		addInstr(encImm(cpuPkg::opAddi, 2, 1, -7));
		addInstr(encReg(cpuPkg::opAdd, 3, 2, 1));
		addInstr(encImm(cpuPkg::opStore, 3, 0, 16'h0104));
		addInstr(encReg(cpuPkg::opSub, 4, 3, 2));
		addInstr(encImm(cpuPkg::opStore, 4, 0, 16'h0108));
		addInstr(encReg(cpuPkg::opAnd, 5, 4, 3));
		addInstr(encImm(cpuPkg::opStore, 5, 0, 16'h010c));
		addInstr(encReg(cpuPkg::opOr, 6, 5, 4));
		addInstr(encImm(cpuPkg::opStore, 6, 0, 16'h0110));
		addInstr(encReg(cpuPkg::opXor, 7, 6, 5));
		addInstr(encImm(cpuPkg::opStore, 7, 0, 16'h0114));
		addInstr(encReg(cpuPkg::opAdd, 0, 7, 7));
		addInstr(encReg(cpuPkg::opAdd, 8, 0, 7));
		addInstr(encImm(cpuPkg::opStore, 8, 0, 16'h0118));
		addInstr(encImm(cpuPkg::opHalt, 0, 0, 0));
		progLen[0] = progWords.size() - progStart[0];

		// Loads used by the very next instruction
		progStart[1] = progWords.size();
		addInstr(encImm(cpuPkg::opAddi, 10, 0, 16'h0200));
		addInstr(encImm(cpuPkg::opLoad, 1, 10, 8));
		addInstr(encReg(cpuPkg::opAdd, 2, 1, 1));
		addInstr(encImm(cpuPkg::opStore, 2, 10, 16'h0020));
		addInstr(encImm(cpuPkg::opLoad, 3, 10, 12));
		addInstr(encImm(cpuPkg::opStore, 3, 10, 16'h0024));
		addInstr(encImm(cpuPkg::opLoad, 4, 10, 16));
		addInstr(encImm(cpuPkg::opAddi, 5, 4, 3));
		addInstr(encImm(cpuPkg::opLoad, 6, 10, 16'h0020));
		addInstr(encReg(cpuPkg::opSub, 7, 6, 5));
		addInstr(encImm(cpuPkg::opStore, 7, 10, 16'h0028));
		addInstr(encImm(cpuPkg::opHalt, 0, 0, 0));
		progLen[1] = progWords.size() - progStart[1];

		// Random mix over r0..r7, word addresses off r0
		progStart[2] = progWords.size();
		for (int i = 1; i < 8; i++)
			addInstr(encImm(cpuPkg::opAddi, i, 0, $urandom_range(16'hffff, 0)));
		for (int i = 7; i < RANDOM_LEN - 1; i++) begin
			kind = $urandom_range(5, 0);
			rd = $urandom_range(7, 0);
			rs = $urandom_range(7, 0);
			rt = $urandom_range(7, 0);
			case (kind)
				0, 1: addInstr(encReg(aluOp($urandom_range(4, 0)), rd, rs, rt));
				2: addInstr(encImm(cpuPkg::opAddi, rd, rs, $urandom_range(16'hffff, 0)));
				3: addInstr(encImm(cpuPkg::opLoad, rd, 0, 4 * $urandom_range(255, 0)));
				4: addInstr(encImm(cpuPkg::opStore, rd, 0, 4 * $urandom_range(255, 0)));
				default: addInstr(32'h0);
			endcase
		end
		addInstr(encImm(cpuPkg::opHalt, 0, 0, 0));
		progLen[2] = progWords.size() - progStart[2];

		// Stores after the halt must never reach the data port
		progStart[3] = progWords.size();
		addInstr(encImm(cpuPkg::opAddi, 1, 0, 16'h0055));
		addInstr(encImm(cpuPkg::opStore, 1, 0, 16'h0080));
		addInstr(encImm(cpuPkg::opAddi, 2, 1, 1));
		addInstr(encImm(cpuPkg::opHalt, 0, 0, 0));
		addInstr(encImm(cpuPkg::opStore, 2, 0, 16'h0084));
		addInstr(encImm(cpuPkg::opAddi, 3, 0, 9));
		addInstr(encImm(cpuPkg::opStore, 3, 0, 16'h0088));
		addInstr(encImm(cpuPkg::opHalt, 0, 0, 0));
		progLen[3] = progWords.size() - progStart[3];

		totalInstr = progWords.size();
	endtask

	task automatic checkResetState();
		int errorsBefore;
		errorsBefore = errorCount;
		repeat (8) @(posedge clk);
		checkValue("instrValid", instrValid, 0);
		checkValue("dataReq.valid", dataReq.valid, 0);
		checkValue("dataReq.write", dataReq.write, 0);
		checkValue("halt", halt, 0);
		testsRun++;
		if (errorCount == errorsBefore) begin
			$display("Test 1 reset state: ok");
		end else begin
			testsFailed++;
			$display("Test 1 reset state: %0d errors", errorCount - errorsBefore);
		end
	endtask

	task automatic runTest(input int num, input string name, input int which, input bit waits);
		int errorsBefore;
		int retired;
		int logBefore;
		errorsBefore = errorCount;
		@(negedge clk);
		rst_n = 1'b0;
		checking = 1'b0;
		waitEnable = waits;
		logBefore = dataMem.storeLog.size();
		for (int i = 0; i < MEM_WORDS; i++) begin
			if (i < progLen[which])
				instrMem.mem[i] = progWords[progStart[which] + i];
			else
				instrMem.mem[i] = nopFill(i);
			dataMem.mem[i] = fillWord(i);
		end
		retired = runReference(progStart[which], progLen[which]);
		storeIdx = 0;
		fetchAddr = 32'h0;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		checking = 1'b1;

		do
			@(posedge clk);
		while (!halt);
		checkValue("stores logged at halt", dataMem.storeLog.size() - logBefore, expAddr.size());

		// A fetch opened before the drain may still be finishing
		repeat (SETTLE_CYCLES) @(posedge clk);
		for (int i = 0; i < HOLD_CYCLES; i++) begin
			@(posedge clk);
			checkValue("halt", halt, 1);
			checkValue("instrValid", instrValid, 0);
		end
		checkValue("stores logged", dataMem.storeLog.size() - logBefore, expAddr.size());
		checkValue("stores compared", storeIdx, expAddr.size());
		for (int i = 0; i < MEM_WORDS; i++)
			checkValue($sformatf("dataMem.mem[%0d]", i), dataMem.mem[i], refMem[i]);
		checking = 1'b0;

		testsRun++;
		if (errorCount == errorsBefore) begin
			$display("Test %0d %s: ok, %0d instructions retired, %0d stores",
				num, name, retired, expAddr.size());
		end else begin
			testsFailed++;
			$display("Test %0d %s: %0d errors", num, name, errorCount - errorsBefore);
		end
	endtask

	// Fetch addresses run in order from zero, one word per transfer
	always @(posedge clk) begin
		if (checking && rst_n && instrValid && instrReady) begin
			checkValue("instrAddr", instrAddr, fetchAddr);
			fetchAddr = fetchAddr + 32'd4;
		end
	end

	// Each store on the data port against the reference order
	always @(posedge clk) begin
		if (checking && rst_n && dataReq.valid && dataReq.write && dataReady) begin
			if (storeIdx < expAddr.size()) begin
				checkValue("dataReq.addr", dataReq.addr, expAddr[storeIdx]);
				checkValue("dataReq.wrData", dataReq.wrData, expData[storeIdx]);
			end else begin
				$display("Unexpected store at %0t ns to address %h, the program has only %0d stores",
					$time, dataReq.addr, expAddr.size());
				errorCount++;
			end
			storeIdx++;
		end
	end

	initial begin
		rst_n = 1'b0;
		waitEnable = 1'b0;
		checking = 1'b0;
		storeIdx = 0;
		fetchAddr = 32'h0;
		errorCount = 0;
		testsRun = 0;
		testsFailed = 0;
		totalInstr = 0;
		void'($urandom(32'h5ee4));
		for (int i = 0; i < 1024; i++) begin
			instrMem.waitTable[i] = $urandom_range(3, 0);
			dataMem.waitTable[i] = $urandom_range(3, 0);
		end
		buildPrograms();
		checkResetState();
		runTest(2, "forwarding", 0, 1'b0);
		runTest(3, "load-use stall", 1, 1'b0);
		runTest(4, "random program with port waits", 2, 1'b1);
		runTest(5, "halt", 3, 1'b1);
		$display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
		if (errorCount == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		wait (totalInstr > 0);
		#(40 * totalInstr * 10);
		$display("Watchdog: the tests did not finish within %0d ns", 40 * totalInstr * 10);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+hdl
hdl/cpuPkg.sv
hdl/pipelineControl.sv
hdl/fetchUnit.sv
hdl/registerFile.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/memoryStage.sv
hdl/cpuTop.sv
sim/tbMemories.sv
sim/cpuTb.sv
